//--- Makefile
VERILATOR  ?= verilator
TOP        := lsu_subsys_tb
FILELIST   := lsu_subsys.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Verification failed
PASS_MSG   := Verification passed
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported a failure, see $(LOG)"; \
	  exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ended without a result line, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- lsu_subsys.f
rtl/lsu_pkg.sv
rtl/mem_wait_timer.sv
rtl/data_mem.sv
rtl/lsu_ctrl.sv
rtl/lsu_datapath.sv
rtl/lsu_subsys.sv
sim/lsu_subsys_tb.sv

//--- rtl/data_mem.sv
`timescale 1ns/1ps

module data_mem (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           r_valid_i,
  input  logic [lsu_pkg::ADDR_WIDTH-1:0] r_addr_i,
  input  logic                           w_valid_i,
  input  logic [lsu_pkg::ADDR_WIDTH-1:0] w_addr_i,
  input  logic [lsu_pkg::DATA_WIDTH-1:0] w_data_i,
  input  logic [lsu_pkg::STRB_WIDTH-1:0] w_strb_i,
  output logic                           r_ready_o,
  output logic [lsu_pkg::DATA_WIDTH-1:0] r_data_o,
  output logic                           w_ready_o
);
  import lsu_pkg::*;

  logic [DATA_WIDTH-1:0]     mem [MEM_WORDS];
  logic [MEM_INDEX_BITS-1:0] r_idx;
  logic [MEM_INDEX_BITS-1:0] w_idx;
  logic                      pending_q;
  logic                      start;
  logic                      expire;

  // upper address bits are dropped, so accesses wrap
  assign r_idx = r_addr_i[MEM_INDEX_MSB:MEM_INDEX_LSB];
  assign w_idx = w_addr_i[MEM_INDEX_MSB:MEM_INDEX_LSB];

  // first cycle of a new request kicks the timer
  assign start = (r_valid_i || w_valid_i) && !pending_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      pending_q <= 1'b0;
    end else if (expire) begin
      pending_q <= 1'b0;
    end else if (start) begin
      pending_q <= 1'b1;
    end
  end

  mem_wait_timer wait_timer_i (
    .clk      (clk),
    .reset    (reset),
    .start_i  (start),
    .expire_o (expire)
  );

  // the channel whose valid is up gets the ready
  assign r_ready_o = expire && r_valid_i;
  assign w_ready_o = expire && w_valid_i;

  // read data is only meaningful while r_ready_o is high
  assign r_data_o = mem[r_idx];

  // byte lanes written at the ready edge
  always_ff @(posedge clk) begin
    if (w_ready_o) begin
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (w_strb_i[i]) begin
          mem[w_idx][i*8 +: 8] <= w_data_i[i*8 +: 8];
        end
      end
    end
  end

endmodule

//--- rtl/lsu_ctrl.sv
`timescale 1ns/1ps

module lsu_ctrl (
  input  logic             clk,
  input  logic             reset,
  input  lsu_pkg::lsu_op_e lsu_op_i,
  input  logic             ifu_stall_i,
  input  logic             r_ready_i,
  input  logic             w_ready_i,
  output logic             capture_o,
  output logic             r_valid_o,
  output logic             w_valid_o,
  output logic             rd_wen_o,
  output logic             mem_stall_o
);
  import lsu_pkg::*;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    READ  = 2'd1,
    WRITE = 2'd2
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   completing;

  // new op only taken while idle and the fetch side is not stalled
  assign capture_o = (state_q == IDLE) && (lsu_op_i != LSU_OP_NONE) && !ifu_stall_i;

  assign r_valid_o = (state_q == READ);
  assign w_valid_o = (state_q == WRITE);

  // access ends in the cycle the matching ready is high
  assign completing = (r_valid_o && r_ready_i) || (w_valid_o && w_ready_i);

  // loads write back in their completion cycle
  assign rd_wen_o = r_valid_o && r_ready_i;

  // hold upstream while busy, release in the completion cycle
  assign mem_stall_o = (state_q != IDLE) && !completing;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (capture_o) begin
          if (lsu_op_i == LSU_OP_LOAD) begin
            state_d = READ;
          end else begin
            state_d = WRITE;
          end
        end
      end
      READ: begin
        if (r_ready_i) begin
          state_d = IDLE;
        end
      end
      WRITE: begin
        if (w_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- rtl/lsu_datapath.sv
`timescale 1ns/1ps

module lsu_datapath (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           capture_i,
  input  lsu_pkg::lsu_op_e               lsu_op_i,
  input  logic [2:0]                     funct3_i,
  input  logic [lsu_pkg::DATA_WIDTH-1:0] src1_i,
  input  logic [lsu_pkg::DATA_WIDTH-1:0] src2_i,
  input  logic [lsu_pkg::DATA_WIDTH-1:0] imm_i,
  input  logic [lsu_pkg::DATA_WIDTH-1:0] r_data_i,
  output logic [lsu_pkg::ADDR_WIDTH-1:0] addr_o,
  output logic [lsu_pkg::DATA_WIDTH-1:0] w_data_o,
  output logic [lsu_pkg::STRB_WIDTH-1:0] w_strb_o,
  output logic [lsu_pkg::DATA_WIDTH-1:0] result_o
);
  import lsu_pkg::*;

  logic [ADDR_WIDTH-1:0]      addr_q;
  logic [DATA_WIDTH-1:0]      store_q;
  logic [2:0]                 funct3_q;
  logic                       is_load_q;
  logic [BYTE_OFF_BITS-1:0]   byte_off;
  logic [BYTE_OFF_BITS+2:0]   bit_off;
  logic [DATA_WIDTH-1:0]      load_word;

  // op kind of the access in flight
  always_ff @(posedge clk) begin
    if (reset) begin
      is_load_q <= 1'b0;
    end else if (capture_i) begin
      is_load_q <= (lsu_op_i == LSU_OP_LOAD);
    end
  end

  // operands stay put for the whole access
  always_ff @(posedge clk) begin
    if (capture_i) begin
      addr_q   <= ADDR_WIDTH'(src1_i + imm_i);
      store_q  <= src2_i;
      funct3_q <= funct3_i;
    end
  end

  assign addr_o   = addr_q;
  assign byte_off = addr_q[BYTE_OFF_BITS-1:0];
  assign bit_off  = {byte_off, 3'b000};

  // store data moved up into its lanes
  assign w_data_o = store_q << bit_off;

  always_comb begin
    w_strb_o = '0;
    if (!is_load_q) begin
      case (funct3_q)
        F3_B:    w_strb_o = STRB_WIDTH'(1) << byte_off;
        F3_H:    w_strb_o = STRB_WIDTH'(3) << byte_off;
        F3_W:    w_strb_o = '1;
        default: w_strb_o = '0;
      endcase
    end
  end

  // addressed lane brought down to bit 0
  assign load_word = r_data_i >> bit_off;

  always_comb begin
    result_o = '0;
    if (is_load_q) begin
      case (funct3_q)
        F3_B:    result_o = {{(DATA_WIDTH - 8){load_word[7]}}, load_word[7:0]};
        F3_H:    result_o = {{(DATA_WIDTH - 16){load_word[15]}}, load_word[15:0]};
        F3_W:    result_o = load_word;
        F3_BU:   result_o = {{(DATA_WIDTH - 8){1'b0}}, load_word[7:0]};
        F3_HU:   result_o = {{(DATA_WIDTH - 16){1'b0}}, load_word[15:0]};
        // unknown funct3 still completes and returns zero
        default: result_o = '0;
      endcase
    end
  end

endmodule

//--- rtl/lsu_pkg.sv
package lsu_pkg;

  // data path and bus widths
  localparam int DATA_WIDTH = 32;
  localparam int ADDR_WIDTH = 32;

  // one strobe bit per byte lane
  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  // byte offset within a word, taken from the low address bits
  localparam int BYTE_OFF_BITS = $clog2(STRB_WIDTH);

  // memory operation coming from decode
  typedef enum logic [1:0] {
    LSU_OP_NONE  = 2'd0,
    LSU_OP_LOAD  = 2'd1,
    LSU_OP_STORE = 2'd2
  } lsu_op_e;

  // funct3 codes for RV32I loads and stores
  // stores only use the first three
  localparam logic [2:0] F3_B  = 3'd0;
  localparam logic [2:0] F3_H  = 3'd1;
  localparam logic [2:0] F3_W  = 3'd2;
  localparam logic [2:0] F3_BU = 3'd4;
  localparam logic [2:0] F3_HU = 3'd5;

  // data memory geometry
  localparam int MEM_WORDS      = 256;
  localparam int MEM_INDEX_BITS = 8;

  // word index sits just above the byte offset and upper bits wrap
  localparam int MEM_INDEX_LSB = BYTE_OFF_BITS;
  localparam int MEM_INDEX_MSB = MEM_INDEX_LSB + MEM_INDEX_BITS - 1;

  // cycles from the first valid seen to ready
  localparam int MEM_WAIT_CYCLES = 3;

  // wide enough to hold MEM_WAIT_CYCLES
  localparam int WAIT_CNT_WIDTH = $clog2(MEM_WAIT_CYCLES + 1);

endpackage

//--- rtl/lsu_subsys.sv
`timescale 1ns/1ps

module lsu_subsys (
  input  logic                           clk,
  input  logic                           reset,
  input  lsu_pkg::lsu_op_e               lsu_op_i,
  input  logic [2:0]                     funct3_i,
  input  logic [lsu_pkg::DATA_WIDTH-1:0] src1_i,
  input  logic [lsu_pkg::DATA_WIDTH-1:0] src2_i,
  input  logic [lsu_pkg::DATA_WIDTH-1:0] imm_i,
  input  logic                           ifu_stall_i,
  output logic                           mem_stall_o,
  output logic                           lsu_rd_wen_o,
  output logic [lsu_pkg::DATA_WIDTH-1:0] lsu_result_o
);
  import lsu_pkg::*;

  logic                  capture;
  logic                  r_valid;
  logic                  r_ready;
  logic [DATA_WIDTH-1:0] r_data;
  logic                  w_valid;
  logic                  w_ready;
  logic [ADDR_WIDTH-1:0] addr;
  logic [DATA_WIDTH-1:0] w_data;
  logic [STRB_WIDTH-1:0] w_strb;

  lsu_ctrl ctrl_i (
    .clk         (clk),
    .reset       (reset),
    .lsu_op_i    (lsu_op_i),
    .ifu_stall_i (ifu_stall_i),
    .r_ready_i   (r_ready),
    .w_ready_i   (w_ready),
    .capture_o   (capture),
    .r_valid_o   (r_valid),
    .w_valid_o   (w_valid),
    .rd_wen_o    (lsu_rd_wen_o),
    .mem_stall_o (mem_stall_o)
  );

  lsu_datapath datapath_i (
    .clk       (clk),
    .reset     (reset),
    .capture_i (capture),
    .lsu_op_i  (lsu_op_i),
    .funct3_i  (funct3_i),
    .src1_i    (src1_i),
    .src2_i    (src2_i),
    .imm_i     (imm_i),
    .r_data_i  (r_data),
    .addr_o    (addr),
    .w_data_o  (w_data),
    .w_strb_o  (w_strb),
    .result_o  (lsu_result_o)
  );

  // one latched address serves both channels
  data_mem mem_i (
    .clk       (clk),
    .reset     (reset),
    .r_valid_i (r_valid),
    .r_addr_i  (addr),
    .w_valid_i (w_valid),
    .w_addr_i  (addr),
    .w_data_i  (w_data),
    .w_strb_i  (w_strb),
    .r_ready_o (r_ready),
    .r_data_o  (r_data),
    .w_ready_o (w_ready)
  );

endmodule

//--- rtl/mem_wait_timer.sv
`timescale 1ns/1ps

module mem_wait_timer (
  input  logic clk,
  input  logic reset,
  input  logic start_i,
  output logic expire_o
);
  import lsu_pkg::*;

  logic [WAIT_CNT_WIDTH-1:0] count_q;
  logic                      running_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      count_q   <= '0;
      running_q <= 1'b0;
    end else if (!running_q) begin
      // start only counts from idle
      if (start_i) begin
        count_q   <= WAIT_CNT_WIDTH'(MEM_WAIT_CYCLES - 1);
        running_q <= 1'b1;
      end
    end else if (count_q == '0) begin
      running_q <= 1'b0;
    end else begin
      count_q <= count_q - 1'b1;
    end
  end

  // one cycle pulse on the last count
  assign expire_o = running_q && (count_q == '0);

endmodule

//--- sim/lsu_subsys_tb.sv
`timescale 1ns/1ps

module lsu_subsys_tb;
  import lsu_pkg::*;

  typedef struct {
    lsu_op_e     op;
    logic [2:0]  f3;
    logic [31:0] src1;
    logic [31:0] imm;
    logic [31:0] src2;
    bit          rnd;
    bit          hold;
  } op_entry_t;

  // every byte lane and half has its top bit set in one word and clear in the other
  localparam logic [31:0] WORD_A = 32'h817e_9205;
  localparam logic [31:0] WORD_B = 32'h1ce3_40f7;
  localparam logic [31:0] BG     = 32'h5a5a_5a5a;
  localparam logic [31:0] NEG16  = 32'hffff_fff0;

  logic                  clk;
  logic                  reset;
  lsu_op_e               lsu_op;
  logic [2:0]            funct3;
  logic [DATA_WIDTH-1:0] src1;
  logic [DATA_WIDTH-1:0] src2;
  logic [DATA_WIDTH-1:0] imm;
  logic                  ifu_stall;
  logic                  mem_stall;
  logic                  rd_wen;
  logic [DATA_WIDTH-1:0] result;

  op_entry_t   table_q[$];
  logic [7:0]  shadow [1024];
  logic [31:0] lcg_state;
  int          errors;
  int          checks;
  int          cycle_count;
  int          cycle_limit;

  lsu_subsys lsu_subsys_i (
    .clk          (clk),
    .reset        (reset),
    .lsu_op_i     (lsu_op),
    .funct3_i     (funct3),
    .src1_i       (src1),
    .src2_i       (src2),
    .imm_i        (imm),
    .ifu_stall_i  (ifu_stall),
    .mem_stall_o  (mem_stall),
    .lsu_rd_wen_o (rd_wen),
    .lsu_result_o (result)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic add_op(input lsu_op_e op, input logic [2:0] f3, input logic [31:0] src1_v,
                        input logic [31:0] imm_v, input logic [31:0] src2_v,
                        input bit rnd, input bit hold);
    op_entry_t e;
    e.op   = op;
    e.f3   = f3;
    e.src1 = src1_v;
    e.imm  = imm_v;
    e.src2 = src2_v;
    e.rnd  = rnd;
    e.hold = hold;
    table_q.push_back(e);
  endtask

  // expected load value from the byte model with a 1 KiB wrap
  function automatic logic [31:0] expected_load(input logic [31:0] addr, input logic [2:0] f3);
    logic [9:0]  a;
    logic [7:0]  b;
    logic [15:0] h;
    logic [31:0] w;
    a = addr[9:0];
    b = shadow[a];
    h = {shadow[a + 10'd1], shadow[a]};
    w = {shadow[a + 10'd3], shadow[a + 10'd2], h};
    case (f3)
      F3_B:    return {{24{b[7]}}, b};
      F3_H:    return {{16{h[15]}}, h};
      F3_W:    return w;
      F3_BU:   return {24'h0, b};
      F3_HU:   return {16'h0, h};
      default: return 32'h0;
    endcase
  endfunction

  task automatic apply_store(input logic [31:0] addr, input logic [2:0] f3,
                             input logic [31:0] data);
    logic [9:0] a;
    int         n;
    a = addr[9:0];
    case (f3)
      F3_B:    n = 1;
      F3_H:    n = 2;
      F3_W:    n = 4;
      default: n = 0;
    endcase
    for (int i = 0; i < n; i++) begin
      shadow[a + 10'(i)] = data[8*i +: 8];
    end
  endtask

  task automatic build_table();
    int k;
    // word round trip, once through a negative immediate
    add_op(LSU_OP_STORE, F3_W, 32'h100, 32'h0, 32'h0, 1, 0);
    add_op(LSU_OP_LOAD, F3_W, 32'h100, 32'h0, 32'h0, 0, 0);
    add_op(LSU_OP_STORE, F3_W, 32'h110, NEG16, 32'h0, 1, 0);
    add_op(LSU_OP_LOAD, F3_W, 32'h0f0, 32'h10, 32'h0, 0, 0);
    // sb on each lane over a known background
    for (k = 0; k < 4; k++) begin
      add_op(LSU_OP_STORE, F3_W, 32'h200, 32'h0, BG, 0, 0);
      add_op(LSU_OP_STORE, F3_B, 32'h200, 32'(k), 32'h0, 1, 0);
      add_op(LSU_OP_LOAD, F3_W, 32'h200, 32'h0, 32'h0, 0, 0);
    end
    for (k = 0; k < 4; k += 2) begin
      add_op(LSU_OP_STORE, F3_W, 32'h204, 32'h0, BG, 0, 0);
      add_op(LSU_OP_STORE, F3_H, 32'h204, 32'(k), 32'h0, 1, 0);
      add_op(LSU_OP_LOAD, F3_W, 32'h204, 32'h0, 32'h0, 0, 0);
    end
    // sign and zero extension on every lane
    add_op(LSU_OP_STORE, F3_W, 32'h300, 32'h0, WORD_A, 0, 0);
    add_op(LSU_OP_STORE, F3_W, 32'h304, 32'h0, WORD_B, 0, 0);
    for (k = 0; k < 8; k++) begin
      add_op(LSU_OP_LOAD, F3_B, 32'h300, 32'(k), 32'h0, 0, 0);
      add_op(LSU_OP_LOAD, F3_BU, 32'h300, 32'(k), 32'h0, 0, 0);
    end
    for (k = 0; k < 8; k += 2) begin
      add_op(LSU_OP_LOAD, F3_H, 32'h300, 32'(k), 32'h0, 0, 0);
      add_op(LSU_OP_LOAD, F3_HU, 32'h300, 32'(k), 32'h0, 0, 0);
    end
    add_op(LSU_OP_LOAD, F3_W, 32'h304, 32'h0, 32'h0, 0, 0);
    // unknown funct3 loads give zero and stores write nothing
    add_op(LSU_OP_LOAD, 3'd3, 32'h300, 32'h0, 32'h0, 0, 0);
    add_op(LSU_OP_LOAD, 3'd7, 32'h304, 32'h0, 32'h0, 0, 0);
    add_op(LSU_OP_STORE, 3'd3, 32'h300, 32'h0, 32'h0, 1, 0);
    add_op(LSU_OP_LOAD, F3_W, 32'h300, 32'h0, 32'h0, 0, 0);
    // high address bits wrap onto the same words
    add_op(LSU_OP_STORE, F3_W, 32'h400, 32'h104, 32'h0, 1, 0);
    add_op(LSU_OP_LOAD, F3_W, 32'h104, 32'h0, 32'h0, 0, 0);
    add_op(LSU_OP_LOAD, F3_W, 32'hffff_fc00, 32'h104, 32'h0, 0, 0);
    add_op(LSU_OP_STORE, F3_B, 32'h1100, 32'h7, 32'h0, 1, 0);
    add_op(LSU_OP_LOAD, F3_BU, 32'h104, 32'h3, 32'h0, 0, 0);
    // ops offered under ifu stall never start
    add_op(LSU_OP_STORE, F3_W, 32'h104, 32'h0, 32'hdead_beef, 0, 1);
    add_op(LSU_OP_LOAD, F3_W, 32'h104, 32'h0, 32'h0, 0, 1);
    add_op(LSU_OP_LOAD, F3_W, 32'h104, 32'h0, 32'h0, 0, 0);
  endtask

  task automatic run_entry(input op_entry_t e);
    logic [31:0] data;
    logic [31:0] addr;
    logic [31:0] exp_result;
    int          waited;
    data = e.rnd ? next_random() : e.src2;
    addr = e.src1 + e.imm;
    @(negedge clk);
    check_value(mem_stall, 1'b0, $sformatf("stall before issue at %h", addr));
    lsu_op    = e.op;
    funct3    = e.f3;
    src1      = e.src1;
    imm       = e.imm;
    src2      = data;
    ifu_stall = e.hold;
    if (e.hold) begin
      repeat (MEM_WAIT_CYCLES + 2) begin
        @(negedge clk);
        check_value(mem_stall, 1'b0, $sformatf("stall for op held at %h", addr));
        check_value(rd_wen, 1'b0, $sformatf("write enable for op held at %h", addr));
      end
      lsu_op    = LSU_OP_NONE;
      ifu_stall = 1'b0;
    end else begin
      exp_result = expected_load(addr, e.f3);
      waited     = 0;
      do begin
        @(negedge clk);
        lsu_op = LSU_OP_NONE;
        waited++;
        if (mem_stall) begin
          check_value(rd_wen, 1'b0, $sformatf("write enable while stalled at %h", addr));
        end
      end while (mem_stall);
      check_value(waited, MEM_WAIT_CYCLES + 1, $sformatf("cycles to completion at %h", addr));
      check_value(rd_wen, e.op == LSU_OP_LOAD,
                  $sformatf("write enable at completion, op %0d", e.op));
      if (e.op == LSU_OP_LOAD) begin
        check_value(result, exp_result, $sformatf("load f3 %0d at %h", e.f3, addr));
      end else begin
        check_value(result, 32'h0, $sformatf("result of store at %h", addr));
        apply_store(addr, e.f3, data);
      end
    end
  endtask

  initial begin
    int idx;
    clk         = 1'b0;
    reset       = 1'b1;
    lsu_op      = LSU_OP_NONE;
    funct3      = 3'd0;
    src1        = '0;
    src2        = '0;
    imm         = '0;
    ifu_stall   = 1'b0;
    errors      = 0;
    checks      = 0;
    cycle_count = 0;
    lcg_state   = 32'd12;
    build_table();
    cycle_limit = table_q.size() * (MEM_WAIT_CYCLES + 6) + 50;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_value(mem_stall, 1'b0, "stall after reset");
    check_value(rd_wen, 1'b0, "write enable after reset");
    for (idx = 0; idx < table_q.size(); idx++) begin
      run_entry(table_q[idx]);
    end
    @(negedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
